/* hdl/addr_route_cfg.svh */
// build-time sizes for the router; data width must be at least 32 and at least the address width
`ifndef ADDR_ROUTE_CFG_SVH
`define ADDR_ROUTE_CFG_SVH

// number of rules held in the address map
`define ADDR_ROUTE_NO_RULES 4

// number of target strobes behind the router
`define ADDR_ROUTE_NO_TARGETS 4

// request and rule address width in bits
`define ADDR_ROUTE_ADDR_WIDTH 32

// write data and configuration data width in bits
`define ADDR_ROUTE_DATA_WIDTH 32

// bit of the configuration data that enables the default target
`define ADDR_ROUTE_DEF_EN_BIT 31

`endif

/* hdl/addr_route_pkg.sv */
// shared types for the router; index widths fall back to one bit when a count is one
package addr_route_pkg;

  `include "addr_route_cfg.svh"

  // request address, also used for rule bounds
  typedef logic [`ADDR_ROUTE_ADDR_WIDTH-1:0] addr_t;

  // request write data and configuration data
  typedef logic [`ADDR_ROUTE_DATA_WIDTH-1:0] data_t;

  // target index, wide enough for every target
  typedef logic [((`ADDR_ROUTE_NO_TARGETS > 1) ?
                  $clog2(`ADDR_ROUTE_NO_TARGETS) : 1)-1:0] idx_t;

  // selects one rule on a configuration write
  typedef logic [((`ADDR_ROUTE_NO_RULES > 1) ?
                  $clog2(`ADDR_ROUTE_NO_RULES) : 1)-1:0] rule_sel_t;

  // one map entry: start is included, end is excluded
  // start at or above end matches nothing
  typedef struct packed {
    idx_t  idx;
    addr_t start_addr;
    addr_t end_addr;
  } rule_t;

  // register written by one configuration strobe
  // for CFG_DEFAULT the enable sits at the top data bit, the index in the low bits
  typedef enum logic [1:0] {
    CFG_START   = 2'd0,
    CFG_END     = 2'd1,
    CFG_IDX     = 2'd2,
    CFG_DEFAULT = 2'd3
  } cfg_field_e;

endpackage

/* hdl/req_if.sv */
// single-cycle request strobe with no back-pressure; the sink must take every strobe
`timescale 1ns/100ps

interface req_if
  import addr_route_pkg::*;
();

  // request strobe, high for one cycle per request
  logic  valid;
  // target address of the request
  addr_t addr;
  // write enable, passed through to the target
  logic  we;
  // write data, passed through to the target
  data_t wdata;

  // side that issues the request
  modport source (
    output valid, addr, we, wdata
  );

  // side that consumes the request
  modport sink (
    input valid, addr, we, wdata
  );

endinterface

/* hdl/addr_map_regs.sv */
// map registers reset to empty rules with the default off; out-of-range rule selects are dropped
`timescale 1ns/100ps
`include "addr_route_cfg.svh"

module addr_map_regs
  import addr_route_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_i,
  // configuration strobe and its fields
  input  logic                             cfg_valid_i,
  input  rule_sel_t                        cfg_sel_i,
  input  cfg_field_e                       cfg_field_i,
  input  data_t                            cfg_wdata_i,
  // current map as seen by the decoder
  output rule_t [`ADDR_ROUTE_NO_RULES-1:0] addr_map_o,
  output logic                             default_en_o,
  output idx_t                             default_idx_o
);

  // rule registers where the highest position has priority in the decoder
  rule_t [`ADDR_ROUTE_NO_RULES-1:0] addr_map_q;
  // default target setting
  logic                             default_en_q;
  idx_t                             default_idx_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      // all-zero rule has start equal to end, so it is empty
      addr_map_q    <= '0;
      default_en_q  <= 1'b0;
      default_idx_q <= '0;
    end else if (cfg_valid_i) begin
      // one field per strobe with the data cut down to the field width
      case (cfg_field_i)
        CFG_START: begin
          addr_map_q[cfg_sel_i].start_addr <= addr_t'(cfg_wdata_i);
        end
        CFG_END: begin
          addr_map_q[cfg_sel_i].end_addr <= addr_t'(cfg_wdata_i);
        end
        CFG_IDX: begin
          addr_map_q[cfg_sel_i].idx <= idx_t'(cfg_wdata_i);
        end
        CFG_DEFAULT: begin
          // rule select plays no part here
          default_en_q  <= cfg_wdata_i[`ADDR_ROUTE_DEF_EN_BIT];
          default_idx_q <= idx_t'(cfg_wdata_i);
        end
      endcase
    end
  end

  // a write lands at the next edge, so a request in the write cycle sees the old map
  assign addr_map_o    = addr_map_q;
  assign default_en_o  = default_en_q;
  assign default_idx_o = default_idx_q;

endmodule

/* hdl/addr_decode.sv */
// purely combinational decode; overlapping rules are legal and empty or inverted rules never match
`timescale 1ns/100ps
`include "addr_route_cfg.svh"

module addr_decode
  import addr_route_pkg::*;
(
  // address of the current request
  input  addr_t                            addr_i,
  // rule at the higher position wins on overlap
  input  rule_t [`ADDR_ROUTE_NO_RULES-1:0] addr_map_i,
  // default target for addresses that match no rule
  input  logic                             en_default_idx_i,
  input  idx_t                             default_idx_i,
  // decode result, valid in the same cycle
  output idx_t                             idx_o,
  output logic                             dec_valid_o,
  output logic                             dec_error_o
);

  // one hit bit per rule
  logic [`ADDR_ROUTE_NO_RULES-1:0] rule_hit;

  // range compare for every rule
  // start is inclusive, end is exclusive
  always_comb begin
    for (int i = 0; i < `ADDR_ROUTE_NO_RULES; i++) begin
      rule_hit[i] = (addr_i >= addr_map_i[i].start_addr) &&
                    (addr_i <  addr_map_i[i].end_addr);
    end
  end

  // priority pick
  // walk upwards so the last hit overwrites earlier ones
  always_comb begin
    // no hit: default index if enabled, else zero
    idx_o = en_default_idx_i ? default_idx_i : '0;
    for (int i = 0; i < `ADDR_ROUTE_NO_RULES; i++) begin
      if (rule_hit[i]) begin
        idx_o = addr_map_i[i].idx;
      end
    end
  end

  // at least one rule claimed the address
  assign dec_valid_o = |rule_hit;

  // nobody claims it and the default is off
  assign dec_error_o = ~dec_valid_o & ~en_default_idx_i;

endmodule

/* hdl/req_router.sv */
// one-cycle router without back-pressure; an index beyond the target count gives no target strobe
`timescale 1ns/100ps
`include "addr_route_cfg.svh"

module req_router
  import addr_route_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_i,
  // incoming request, sampled only while valid
  req_if.sink                                req,
  // same-cycle decode of req.addr
  input  idx_t                               idx_i,
  input  logic                               dec_error_i,
  // target side, strobe is one-hot
  output logic [`ADDR_ROUTE_NO_TARGETS-1:0]  tgt_valid_o,
  output addr_t                              tgt_addr_o,
  output logic                               tgt_we_o,
  output data_t                              tgt_wdata_o,
  // error side for unmapped addresses
  output logic                               err_valid_o,
  output addr_t                              err_addr_o
);

  // one-hot form of the decoded index
  logic [`ADDR_ROUTE_NO_TARGETS-1:0] idx_onehot;
  // strobe registers
  logic [`ADDR_ROUTE_NO_TARGETS-1:0] tgt_valid_q;
  logic                              err_valid_q;
  // request payload, held until the next request
  addr_t                             addr_q;
  logic                              we_q;
  data_t                             wdata_q;

  always_comb begin
    for (int t = 0; t < `ADDR_ROUTE_NO_TARGETS; t++) begin
      idx_onehot[t] = (idx_i == idx_t'(t));
    end
  end

  // strobes last exactly one cycle per request
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tgt_valid_q <= '0;
      err_valid_q <= 1'b0;
    end else begin
      // error and target strobes exclude each other
      tgt_valid_q <= (req.valid && !dec_error_i) ? idx_onehot : '0;
      err_valid_q <= req.valid && dec_error_i;
    end
  end

  // payload follows the strobe, no reset needed
  always_ff @(posedge clk_i) begin
    if (req.valid) begin
      addr_q  <= req.addr;
      we_q    <= req.we;
      wdata_q <= req.wdata;
    end
  end

  assign tgt_valid_o = tgt_valid_q;
  assign tgt_addr_o  = addr_q;
  assign tgt_we_o    = we_q;
  assign tgt_wdata_o = wdata_q;
  assign err_valid_o = err_valid_q;
  // error address shares the payload register with the target side
  assign err_addr_o  = addr_q;

endmodule

/* hdl/addr_route_top.sv */
// router top with plain ports; every request yields one result the next cycle, targets cannot stall
`timescale 1ns/100ps
`include "addr_route_cfg.svh"

module addr_route_top
  import addr_route_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_i,
  // configuration write port
  input  logic                              cfg_valid_i,
  input  rule_sel_t                         cfg_sel_i,
  input  cfg_field_e                        cfg_field_i,
  input  data_t                             cfg_wdata_i,
  // request port
  input  logic                              req_valid_i,
  input  addr_t                             req_addr_i,
  input  logic                              req_we_i,
  input  data_t                             req_wdata_i,
  // target strobes, one cycle after the request
  output logic [`ADDR_ROUTE_NO_TARGETS-1:0] tgt_valid_o,
  output addr_t                             tgt_addr_o,
  output logic                              tgt_we_o,
  output data_t                             tgt_wdata_o,
  // error strobe for unmapped requests
  output logic                              err_valid_o,
  output addr_t                             err_addr_o
);

  // map state from the register file
  rule_t [`ADDR_ROUTE_NO_RULES-1:0] addr_map;
  logic                             default_en;
  idx_t                             default_idx;
  // decode result of the current request
  idx_t                             dec_idx;
  logic                             dec_error;

  // request bus, fed straight from the ports
  req_if req_bus ();

  assign req_bus.valid = req_valid_i;
  assign req_bus.addr  = req_addr_i;
  assign req_bus.we    = req_we_i;
  assign req_bus.wdata = req_wdata_i;

  addr_map_regs u_map_regs (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cfg_valid_i   (cfg_valid_i),
    .cfg_sel_i     (cfg_sel_i),
    .cfg_field_i   (cfg_field_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .addr_map_o    (addr_map),
    .default_en_o  (default_en),
    .default_idx_o (default_idx)
  );

  // router only needs the error flag, the match flag stays open
  addr_decode u_decode (
    .addr_i           (req_bus.addr),
    .addr_map_i       (addr_map),
    .en_default_idx_i (default_en),
    .default_idx_i    (default_idx),
    .idx_o            (dec_idx),
    .dec_valid_o      (),
    .dec_error_o      (dec_error)
  );

  req_router u_router (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req         (req_bus.sink),
    .idx_i       (dec_idx),
    .dec_error_i (dec_error),
    .tgt_valid_o (tgt_valid_o),
    .tgt_addr_o  (tgt_addr_o),
    .tgt_we_o    (tgt_we_o),
    .tgt_wdata_o (tgt_wdata_o),
    .err_valid_o (err_valid_o),
    .err_addr_o  (err_addr_o)
  );

endmodule

/* tb/addr_route_assert.sv */
// strobe assertions bound into every req_router; the failure count is read by the testbench
`timescale 1ns/100ps
`include "addr_route_cfg.svh"

module addr_route_assert (
  input logic                              clk_i,
  input logic                              rst_i,
  input logic                              req_valid_i,
  input logic [`ADDR_ROUTE_NO_TARGETS-1:0] tgt_valid_i,
  input logic                              err_valid_i
);

  // number of assertion failures so far
  int fail_count = 0;

  // at most one target strobe at a time
  a_tgt_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(tgt_valid_i))
    else begin fail_count++; $error("target strobe is not one-hot"); end

  // a request goes to a target or to the error side, never both
  a_tgt_err_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !((|tgt_valid_i) && err_valid_i))
    else begin fail_count++; $error("target and error strobes high together"); end

  // any strobe needs a request on the edge before
  a_strobe_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    ((|tgt_valid_i) || err_valid_i) |-> $past(req_valid_i))
    else begin fail_count++; $error("strobe without a request one cycle earlier"); end

  // and every request gets its strobe
  a_req_gets_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_i |=> ((|tgt_valid_i) || err_valid_i))
    else begin fail_count++; $error("request produced no strobe"); end

  // outputs quiet right after a reset edge
  a_quiet_after_rst: assert property (@(posedge clk_i)
    rst_i |=> ((tgt_valid_i == '0) && !err_valid_i))
    else begin fail_count++; $error("strobe high in the cycle after reset"); end

endmodule

// router strobes watched from inside the design
bind req_router addr_route_assert u_assert (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .req_valid_i (req.valid),
  .tgt_valid_i (tgt_valid_o),
  .err_valid_i (err_valid_o)
);

/* tb/addr_route_checker.sv */
// reference model of the map; predicts on the rising edge, compares on the falling edge
`timescale 1ns/100ps
`include "addr_route_cfg.svh"

module addr_route_checker
  import addr_route_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              cfg_valid_i,
  input  rule_sel_t                         cfg_sel_i,
  input  cfg_field_e                        cfg_field_i,
  input  data_t                             cfg_wdata_i,
  input  logic                              req_valid_i,
  input  addr_t                             req_addr_i,
  input  logic                              req_we_i,
  input  data_t                             req_wdata_i,
  input  logic [`ADDR_ROUTE_NO_TARGETS-1:0] tgt_valid_i,
  input  addr_t                             tgt_addr_i,
  input  logic                              tgt_we_i,
  input  data_t                             tgt_wdata_i,
  input  logic                              err_valid_i,
  input  addr_t                             err_addr_i,
  output int                                error_count_o,
  output int                                check_count_o
);

  // mirror of the map registers
  addr_t mir_start [`ADDR_ROUTE_NO_RULES];
  addr_t mir_end   [`ADDR_ROUTE_NO_RULES];
  idx_t  mir_idx   [`ADDR_ROUTE_NO_RULES];
  logic  mir_def_en;
  idx_t  mir_def_idx;
  // prediction for the next falling edge
  logic [`ADDR_ROUTE_NO_TARGETS-1:0] exp_tgt;
  logic                              exp_err;
  addr_t                             exp_addr;
  logic                              exp_we;
  data_t                             exp_wdata;
  // no prediction exists before the first edge
  logic                              exp_ready = 1'b0;

  initial begin
    error_count_o = 0;
    check_count_o = 0;
  end

  // highest-numbered rule that covers the address or -1 when none does
  function automatic int covering_rule(input addr_t a);
    for (int r = `ADDR_ROUTE_NO_RULES - 1; r >= 0; r--) begin
      if (mir_start[r] <= a && a < mir_end[r]) begin
        return r;
      end
    end
    return -1;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
    check_count_o++;
    if (act_v !== exp_v) begin
      error_count_o++;
      $display("Error: at %0d ns, %s expected %0h, actual %0h", $time, name, exp_v, act_v);
    end
  endtask

  always @(posedge clk_i) begin
    int   hit;
    idx_t tgt;
    exp_ready = 1'b1;
    exp_tgt   = '0;
    exp_err   = 1'b0;
    if (rst_i) begin
      // clear to empty rules with the default off
      for (int r = 0; r < `ADDR_ROUTE_NO_RULES; r++) begin
        mir_start[r] = '0;
        mir_end[r]   = '0;
        mir_idx[r]   = '0;
      end
      mir_def_en  = 1'b0;
      mir_def_idx = '0;
    end else begin
      // predict from the map as it stands before this edge
      if (req_valid_i) begin
        hit = covering_rule(req_addr_i);
        tgt = (hit >= 0) ? mir_idx[hit] : mir_def_idx;
        if (hit < 0 && !mir_def_en) begin
          exp_err = 1'b1;
        end else if (int'(tgt) < `ADDR_ROUTE_NO_TARGETS) begin
          exp_tgt[tgt] = 1'b1;
        end
        exp_addr  = req_addr_i;
        exp_we    = req_we_i;
        exp_wdata = req_wdata_i;
      end
      // then apply the configuration write of this cycle
      if (cfg_valid_i) begin
        case (cfg_field_i)
          CFG_START: mir_start[cfg_sel_i] = cfg_wdata_i[`ADDR_ROUTE_ADDR_WIDTH-1:0];
          CFG_END:   mir_end[cfg_sel_i]   = cfg_wdata_i[`ADDR_ROUTE_ADDR_WIDTH-1:0];
          CFG_IDX:   mir_idx[cfg_sel_i]   = cfg_wdata_i[$bits(idx_t)-1:0];
          default: begin
            mir_def_en  = cfg_wdata_i[`ADDR_ROUTE_DEF_EN_BIT];
            mir_def_idx = cfg_wdata_i[$bits(idx_t)-1:0];
          end
        endcase
      end
    end
  end

  // outputs settle after the rising edge, so check them half a cycle later
  always @(negedge clk_i) begin
    if (exp_ready) begin
      compare_value("tgt_valid_o", exp_tgt, tgt_valid_i);
      compare_value("err_valid_o", exp_err, err_valid_i);
      if (exp_err) begin
        compare_value("err_addr_o", exp_addr, err_addr_i);
      end
      if (|exp_tgt) begin
        compare_value("tgt_addr_o", exp_addr, tgt_addr_i);
        compare_value("tgt_we_o", exp_we, tgt_we_i);
        compare_value("tgt_wdata_o", exp_wdata, tgt_wdata_i);
      end
    end
  end

endmodule

/* tb/addr_route_tb.sv */
// runs five request scenarios on the router top; the checker compares every cycle after reset
`timescale 1ns/100ps
`include "addr_route_cfg.svh"

module addr_route_tb
  import addr_route_pkg::*;
();

  localparam int CLK_PERIOD    = 8;
  localparam int NR            = `ADDR_ROUTE_NO_RULES;
  localparam int N_RESET_REQ   = 20;
  localparam int N_RULE_REQ    = 40;
  localparam int N_OVERLAP_REQ = 30;
  localparam int N_DEFAULT_REQ = 20;
  localparam int N_MIXED       = 200;
  // cycles of all scenarios plus reset and drain
  localparam int PLANNED_CYCLES = 4 + N_RESET_REQ + (3 * NR + N_RULE_REQ + 3 * NR)
                                  + (6 + 1 + N_OVERLAP_REQ) + (2 + 2 * N_DEFAULT_REQ)
                                  + N_MIXED + 5;

  logic                              clk;
  logic                              rst;
  logic                              cfg_valid;
  rule_sel_t                         cfg_sel;
  cfg_field_e                        cfg_field;
  data_t                             cfg_wdata;
  logic                              req_valid;
  addr_t                             req_addr;
  logic                              req_we;
  data_t                             req_wdata;
  logic [`ADDR_ROUTE_NO_TARGETS-1:0] tgt_valid;
  addr_t                             tgt_addr;
  logic                              tgt_we;
  data_t                             tgt_wdata;
  logic                              err_valid;
  addr_t                             err_addr;
  int                                error_count;
  int                                check_count;
  int                                total_errors;
  integer                            seed;

  addr_route_top UUT (
    .clk_i (clk), .rst_i (rst),
    .cfg_valid_i (cfg_valid), .cfg_sel_i (cfg_sel),
    .cfg_field_i (cfg_field), .cfg_wdata_i (cfg_wdata),
    .req_valid_i (req_valid), .req_addr_i (req_addr),
    .req_we_i (req_we), .req_wdata_i (req_wdata),
    .tgt_valid_o (tgt_valid), .tgt_addr_o (tgt_addr),
    .tgt_we_o (tgt_we), .tgt_wdata_o (tgt_wdata),
    .err_valid_o (err_valid), .err_addr_o (err_addr)
  );

  addr_route_checker u_checker (
    .clk_i (clk), .rst_i (rst),
    .cfg_valid_i (cfg_valid), .cfg_sel_i (cfg_sel),
    .cfg_field_i (cfg_field), .cfg_wdata_i (cfg_wdata),
    .req_valid_i (req_valid), .req_addr_i (req_addr),
    .req_we_i (req_we), .req_wdata_i (req_wdata),
    .tgt_valid_i (tgt_valid), .tgt_addr_i (tgt_addr),
    .tgt_we_i (tgt_we), .tgt_wdata_i (tgt_wdata),
    .err_valid_i (err_valid), .err_addr_i (err_addr),
    .error_count_o (error_count), .check_count_o (check_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // one cycle of stimulus, applied on the falling edge
  task automatic drive_cycle(input logic rv, input addr_t ra, input logic rwe, input data_t rwd,
                             input logic cv, input rule_sel_t cs, input cfg_field_e cf,
                             input data_t cd);
    @(negedge clk);
    req_valid = rv;
    req_addr  = ra;
    req_we    = rwe;
    req_wdata = rwd;
    cfg_valid = cv;
    cfg_sel   = cs;
    cfg_field = cf;
    cfg_wdata = cd;
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0, CFG_START, '0);
  endtask

  // request with random write enable and data
  task automatic send_request(input addr_t a);
    data_t rnd;
    rnd = $random(seed);
    drive_cycle(1'b1, a, rnd[0], data_t'($random(seed)), 1'b0, '0, CFG_START, '0);
  endtask

  task automatic write_config(input rule_sel_t sel, input cfg_field_e field, input data_t d);
    drive_cycle(1'b0, '0, 1'b0, '0, 1'b1, sel, field, d);
  endtask

  task automatic write_rule(input rule_sel_t sel, input addr_t s, input addr_t e, input int idx);
    write_config(sel, CFG_START, data_t'(s));
    write_config(sel, CFG_END, data_t'(e));
    write_config(sel, CFG_IDX, data_t'(idx));
  endtask

  // empty map, so every request must end on the error side
  task automatic requests_after_reset();
    repeat (N_RESET_REQ) send_request(addr_t'($random(seed)));
  endtask

  // four disjoint windows of 4 KiB, targets in reverse order
  task automatic disjoint_rule_requests();
    addr_t base;
    int    r;
    for (int i = 0; i < NR; i++) begin
      base = addr_t'(32'h1000_0000 * (i + 1));
      write_rule(rule_sel_t'(i), base, base + 32'h1000, NR - 1 - i);
    end
    for (int i = 0; i < N_RULE_REQ; i++) begin
      r = $unsigned($random(seed)) % NR;
      send_request(addr_t'(32'h1000_0000 * (r + 1)) + ($unsigned($random(seed)) % 32'h1000));
    end
    // bounds: start and end-1 inside, end outside
    for (int i = 0; i < NR; i++) begin
      base = addr_t'(32'h1000_0000 * (i + 1));
      send_request(base);
      send_request(base + 32'h0fff);
      send_request(base + 32'h1000);
    end
  endtask

  // rule 2 overlaps the upper half of rule 0 and must win there
  task automatic overlap_requests();
    write_rule(0, 32'h5000_0000, 32'h5001_0000, 0);
    write_rule(2, 32'h5000_8000, 32'h5001_8000, 2);
    send_request(32'h5000_8000);
    repeat (N_OVERLAP_REQ) send_request(32'h5000_0000 + ($unsigned($random(seed)) % 32'h1_8000));
  endtask

  // addresses above 0xf000_0000 hit no rule
  task automatic default_target_requests();
    data_t rnd;
    write_config(0, CFG_DEFAULT, 32'h8000_0001);
    for (int i = 0; i < 2 * N_DEFAULT_REQ; i++) begin
      if (i == N_DEFAULT_REQ) begin
        write_config(0, CFG_DEFAULT, 32'h0000_0003);
      end
      rnd = $random(seed);
      send_request({4'hf, rnd[27:0]});
    end
  endtask

  // every-cycle traffic mixed with writes into a small address window
  task automatic mixed_traffic();
    data_t a;
    data_t b;
    data_t c;
    data_t d;
    for (int i = 0; i < N_MIXED; i++) begin
      a = $random(seed);
      b = $random(seed);
      c = $random(seed);
      if (b[6:5] == 2'd0 || b[6:5] == 2'd1) begin
        d = 32'h6000_0000 + ($unsigned(c) % 32'h100);
      end else begin
        d = c;
      end
      drive_cycle(a[1:0] != 2'b00, 32'h6000_0000 + ($unsigned(a) % 32'h100), a[8],
                  data_t'($random(seed)), b[2:0] < 3'd3, rule_sel_t'(b[4:3]),
                  cfg_field_e'(b[6:5]), d);
    end
  endtask

  initial begin
    seed      = 70;
    rst       = 1'b1;
    cfg_valid = 1'b0;
    cfg_sel   = '0;
    cfg_field = CFG_START;
    cfg_wdata = '0;
    req_valid = 1'b0;
    req_addr  = '0;
    req_we    = 1'b0;
    req_wdata = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    requests_after_reset();
    disjoint_rule_requests();
    overlap_requests();
    default_target_requests();
    mixed_traffic();
    repeat (3) idle_cycle();
    // step off the falling edge so the last comparison is counted
    @(posedge clk);
    total_errors = error_count + UUT.u_router.u_assert.fail_count;
    $display("checks %0d, value errors %0d, assertion failures %0d",
             check_count, error_count, UUT.u_router.u_assert.fail_count);
    if (total_errors == 0 && check_count > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // watchdog with twice the planned run time
  initial begin
    #(PLANNED_CYCLES * CLK_PERIOD * 2);
    $display("timeout: the run did not finish in %0d ns", PLANNED_CYCLES * CLK_PERIOD * 2);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* list.f */
+incdir+hdl
hdl/addr_route_pkg.sv
hdl/req_if.sv
hdl/addr_map_regs.sv
hdl/addr_decode.sv
hdl/req_router.sv
hdl/addr_route_top.sv
tb/addr_route_assert.sv
tb/addr_route_checker.sv
tb/addr_route_tb.sv
